//--- hw/lc3b_types.sv
`default_nettype none

package lc3b_types;

	// one cache per processor port, port 0 is fetch, port 1 is data
	localparam int NUM_PORTS = 2;

	// cache geometry
	localparam int NUM_LINES = 8;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS = 3;
	localparam int TAG_BITS = 9;

	typedef logic [15:0] lc3b_word;

	// eight words per block
	typedef logic [127:0] lc3b_block;

	// bit 0 low byte, bit 1 high byte
	typedef logic [1:0] lc3b_mem_wmask;

	// processor side request, held until mem_resp
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_word wdata;
		lc3b_mem_wmask wmask;
	} lc3b_mem_req;

	// block request toward physical memory
	typedef struct packed {
		lc3b_word address;
		logic read;
		logic write;
		lc3b_block wdata;
	} lc3b_pmem_req;

endpackage : lc3b_types

`default_nettype wire

//--- hw/l1_cache.sv
`default_nettype none

module l1_cache (
	input  logic                     clk,
	input  logic                     rst_n,
	input  lc3b_types::lc3b_mem_req  mem_req,
	output lc3b_types::lc3b_word     mem_rdata,
	output logic                     mem_resp,
	output lc3b_types::lc3b_pmem_req pmem_req,
	input  lc3b_types::lc3b_block    pmem_rdata,
	input  logic                     pmem_resp
);
	import lc3b_types::*;

	typedef enum logic [2:0] {
		s_idle,
		s_compare,
		s_write_back,
		s_fill,
		s_respond
	} state_e;

	state_e state;
	state_e next_state;

	// line storage
	logic [TAG_BITS-1:0] tag_array [NUM_LINES];
	lc3b_block data_array [NUM_LINES];
	logic [NUM_LINES-1:0] valid_bits;
	logic [NUM_LINES-1:0] dirty_bits;

	// address fields of the current request
	logic [TAG_BITS-1:0] req_tag;
	logic [INDEX_BITS-1:0] req_index;
	logic [OFFSET_BITS-2:0] req_word;

	logic hit;
	logic do_hit;
	logic line_dirty;
	lc3b_block line_data;
	lc3b_block merged_block;
	lc3b_word victim_address;
	lc3b_word fill_address;

	function automatic lc3b_block merge_word(
		input lc3b_block blk,
		input logic [OFFSET_BITS-2:0] sel,
		input lc3b_word wdata,
		input lc3b_mem_wmask wmask
	);
		lc3b_block result;
		result = blk;
		if (wmask[0]) begin
			result[sel * $bits(lc3b_word) +: 8] = wdata[7:0];
		end
		if (wmask[1]) begin
			result[sel * $bits(lc3b_word) + 8 +: 8] = wdata[15:8];
		end
		return result;
	endfunction

	assign req_tag = mem_req.address[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
	assign req_index = mem_req.address[OFFSET_BITS +: INDEX_BITS];
	// byte offset bit 0 only picks the byte within a word
	assign req_word = mem_req.address[OFFSET_BITS-1:1];

	assign line_data = data_array[req_index];
	assign line_dirty = dirty_bits[req_index];
	assign hit = valid_bits[req_index] && (tag_array[req_index] == req_tag);

	// respond state retries the access as a guaranteed hit
	assign do_hit = ((state == s_compare) && hit) || (state == s_respond);
	assign mem_resp = do_hit;
	assign mem_rdata = line_data[req_word * $bits(lc3b_word) +: $bits(lc3b_word)];

	assign merged_block = merge_word(line_data, req_word, mem_req.wdata, mem_req.wmask);

	assign victim_address = {tag_array[req_index], req_index, {OFFSET_BITS{1'b0}}};
	assign fill_address = {req_tag, req_index, {OFFSET_BITS{1'b0}}};

	always_comb begin
		next_state = state;
		pmem_req = '0;
		case (state)
			s_idle: begin
				if (mem_req.read || mem_req.write) begin
					next_state = s_compare;
				end
			end
			s_compare: begin
				if (hit) begin
					next_state = s_idle;
				end else if (line_dirty) begin
					next_state = s_write_back;
				end else begin
					next_state = s_fill;
				end
			end
			s_write_back: begin
				// victim goes back to its own block address
				pmem_req.write = 1'b1;
				pmem_req.address = victim_address;
				pmem_req.wdata = line_data;
				if (pmem_resp) begin
					next_state = s_fill;
				end
			end
			s_fill: begin
				pmem_req.read = 1'b1;
				pmem_req.address = fill_address;
				if (pmem_resp) begin
					next_state = s_respond;
				end
			end
			s_respond: begin
				next_state = s_idle;
			end
			default: begin
				next_state = s_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			valid_bits <= '0;
			dirty_bits <= '0;
		end else begin
			state <= next_state;
			if ((state == s_fill) && pmem_resp) begin
				valid_bits[req_index] <= 1'b1;
				dirty_bits[req_index] <= 1'b0;
			end
			if (do_hit && mem_req.write) begin
				dirty_bits[req_index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == s_fill) && pmem_resp) begin
			tag_array[req_index] <= req_tag;
			data_array[req_index] <= pmem_rdata;
		end else if (do_hit && mem_req.write) begin
			data_array[req_index] <= merged_block;
		end
	end

endmodule : l1_cache

`default_nettype wire

//--- hw/pmem_arbiter.sv
`default_nettype none

module pmem_arbiter (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  lc3b_types::lc3b_pmem_req             pmem_req [lc3b_types::NUM_PORTS],
	output logic [lc3b_types::NUM_PORTS-1:0]     pmem_resp,
	output lc3b_types::lc3b_pmem_req             pmem_out,
	input  logic                                 pmem_resp_in
);
	import lc3b_types::*;

	typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

	logic busy;
	port_idx_t owner;

	// lowest-numbered requester, fetch side wins ties
	port_idx_t pick;
	logic req_any;

	port_idx_t cur;
	logic active;

	always_comb begin
		pick = '0;
		req_any = 1'b0;
		for (int i = NUM_PORTS - 1; i >= 0; i--) begin
			if (pmem_req[i].read || pmem_req[i].write) begin
				pick = port_idx_t'(i);
				req_any = 1'b1;
			end
		end
	end

	// a free arbiter grants in the same cycle
	assign cur = busy ? owner : pick;
	assign active = busy || req_any;

	always_comb begin
		pmem_out = pmem_req[cur];
		if (!active) begin
			pmem_out.read = 1'b0;
			pmem_out.write = 1'b0;
		end
	end

	// only the owner sees the response
	always_comb begin
		pmem_resp = '0;
		if (active) begin
			pmem_resp[cur] = pmem_resp_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= '0;
		end else if (busy) begin
			if (pmem_resp_in) begin
				busy <= 1'b0;
			end
		end else if (req_any && !pmem_resp_in) begin
			// lock the grant until memory answers
			busy <= 1'b1;
			owner <= pick;
		end
	end

endmodule : pmem_arbiter

`default_nettype wire

//--- hw/lc3b_mem.sv
`default_nettype none

module lc3b_mem (
	input  logic                             clk,
	input  logic                             rst_n,
	input  lc3b_types::lc3b_mem_req          mem_req [lc3b_types::NUM_PORTS],
	output lc3b_types::lc3b_word             mem_rdata [lc3b_types::NUM_PORTS],
	output logic [lc3b_types::NUM_PORTS-1:0] mem_resp,
	output lc3b_types::lc3b_pmem_req         pmem_out,
	input  lc3b_types::lc3b_block            pmem_rdata_in,
	input  logic                             pmem_resp_in
);
	import lc3b_types::*;

	// cache to arbiter
	lc3b_pmem_req pmem_req [NUM_PORTS];
	logic [NUM_PORTS-1:0] pmem_resp;

	// port 0 instruction cache, port 1 data cache
	for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_cache
		l1_cache l1_cache_inst (
			.clk,
			.rst_n,
			.mem_req(mem_req[i]),
			.mem_rdata(mem_rdata[i]),
			.mem_resp(mem_resp[i]),
			.pmem_req(pmem_req[i]),
			// read data is shared, only the owner acts on it
			.pmem_rdata(pmem_rdata_in),
			.pmem_resp(pmem_resp[i])
		);
	end

	pmem_arbiter pmem_arbiter_inst (
		.clk,
		.rst_n,
		.pmem_req,
		.pmem_resp,
		.pmem_out,
		.pmem_resp_in
	);

endmodule : lc3b_mem

`default_nettype wire

//--- tests/lc3b_mem_assert.sv
`default_nettype none

module lc3b_mem_assert (
	input logic                             clk,
	input logic                             rst_n,
	input lc3b_types::lc3b_pmem_req         pmem_out,
	input logic [lc3b_types::NUM_PORTS-1:0] pmem_resp,
	input logic                             pmem_resp_in
);
	import lc3b_types::*;

	int fail_count = 0;

	no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_out.read && pmem_out.write))
		else begin
			$error("pmem_out has read and write set together");
			fail_count++;
		end

	// request held until memory answers
	out_held: assert property (@(posedge clk) disable iff (!rst_n)
		((pmem_out.read || pmem_out.write) && !pmem_resp_in) |=> $stable(pmem_out))
		else begin
			$error("pmem_out changed before pmem_resp_in");
			fail_count++;
		end

	// a memory answer reaches exactly one owner
	one_resp: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_resp_in |-> $onehot(pmem_resp))
		else begin
			$error("pmem_resp_in not routed to exactly one pmem_resp bit");
			fail_count++;
		end

	resp_from_memory: assert property (@(posedge clk) disable iff (!rst_n)
		(|pmem_resp) |-> (pmem_resp_in && (pmem_out.read || pmem_out.write)))
		else begin
			$error("pmem_resp high without pmem_resp_in for a pending request");
			fail_count++;
		end

endmodule : lc3b_mem_assert

bind pmem_arbiter lc3b_mem_assert lc3b_mem_assert_inst (
	.clk,
	.rst_n,
	.pmem_out,
	.pmem_resp,
	.pmem_resp_in
);

`default_nettype wire

//--- tests/lc3b_mem_tb.sv
`default_nettype none

module lc3b_mem_tb;
	import lc3b_types::*;

	typedef struct packed {
		logic [7:0] test;
		logic port;
		logic op;
		lc3b_word addr;
		lc3b_word wdata;
		lc3b_mem_wmask mask;
		logic chk;
		lc3b_word exp_data;
		logic [1:0] miss;
		logic par;
	} stim_rec;

	logic clk;
	logic rst_n;
	lc3b_mem_req mem_req [NUM_PORTS];
	lc3b_word mem_rdata [NUM_PORTS];
	logic [NUM_PORTS-1:0] mem_resp;
	lc3b_pmem_req pmem_out;
	lc3b_block pmem_rdata_in;
	logic pmem_resp_in;

	lc3b_block pmem [4096];
	lc3b_word ref_mem [32768];
	logic [31:0] lfsr;
	stim_rec recs [$];
	string test_names [$];
	lc3b_pmem_req out_s;
	logic mem_busy;
	logic [31:0] mem_wait;
	lc3b_word last_read_addr;
	int pm_reads;
	int pm_writes;
	int errors;
	int checks;
	int cycles;
	int limit;

	lc3b_mem lc3b_mem_inst (
		.clk,
		.rst_n,
		.mem_req,
		.mem_rdata,
		.mem_resp,
		.pmem_out,
		.pmem_rdata_in,
		.pmem_resp_in
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic lc3b_block ref_block(input lc3b_word addr);
		lc3b_block b;
		for (int i = 0; i < 8; i++) begin
			b[i * 16 +: 16] = ref_mem[{addr[15:4], 3'(i)}];
		end
		return b;
	endfunction

	// physical memory model acting on pmem_out as sampled at negedge
	always @(negedge clk) begin
		out_s = pmem_out;
	end

	always @(posedge clk) begin
		logic [31:0] d;
		if (!rst_n) begin
			pmem_resp_in <= 1'b0;
			mem_busy = 1'b0;
		end else if (pmem_resp_in) begin
			pmem_resp_in <= 1'b0;
			mem_busy = 1'b0;
		end else if (out_s.read || out_s.write) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				take_bits(2, d);
				mem_wait = d;
				checks++;
				assert (out_s.address[3:0] == 4'h0) else begin
					$display("[FAIL] %0t unaligned pmem address %h", $time, out_s.address);
					errors++;
				end
				if (out_s.read) begin
					pm_reads++;
					last_read_addr = out_s.address;
				end else begin
					pm_writes++;
					checks++;
					assert (out_s.wdata == ref_block(out_s.address)) else begin
						$display("[FAIL] %0t write-back of %h has wrong block contents",
							$time, out_s.address);
						errors++;
					end
				end
			end else if (mem_wait == 0) begin
				pmem_resp_in <= 1'b1;
				if (out_s.read) begin
					pmem_rdata_in <= pmem[out_s.address[15:4]];
				end else begin
					pmem[out_s.address[15:4]] = out_s.wdata;
				end
			end else begin
				mem_wait = mem_wait - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: no response within %0d cycles", limit);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic load_stim();
		int fd;
		int n;
		int port, op, mask, chk, miss, par;
		logic [15:0] addr, wdata, exp_data;
		string line;
		string nm;
		stim_rec rec;
		fd = $fopen("tests/lc3b_mem_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;
			end
			if (line.substr(0, 0) == "T") begin
				n = $sscanf(line, "T %s", nm);
				test_names.push_back(nm);
				continue;
			end
			n = $sscanf(line, "%d %d %h %h %d %d %h %d %d", port, op, addr, wdata, mask,
				chk, exp_data, miss, par);
			if (n != 9) begin
				$display("malformed stimulus line: %0s", line);
				errors++;
				continue;
			end
			rec.test = 8'(test_names.size() - 1);
			rec.port = port[0];
			rec.op = op[0];
			rec.addr = addr;
			rec.wdata = wdata;
			rec.mask = mask[1:0];
			rec.chk = chk[0];
			rec.exp_data = exp_data;
			rec.miss = miss[1:0];
			rec.par = par[0];
			recs.push_back(rec);
		end
		$fclose(fd);
	endtask

	task automatic run_batch(input int first, input int last);
		logic [NUM_PORTS-1:0] pending;
		lc3b_word got [NUM_PORTS];
		lc3b_mem_req req;
		stim_rec rec;
		lc3b_word exp;
		int rd0;
		int wr0;
		rd0 = pm_reads;
		wr0 = pm_writes;
		pending = '0;
		@(posedge clk);
		for (int r = first; r <= last; r++) begin
			rec = recs[r];
			req.address = rec.addr;
			req.read = !rec.op;
			req.write = rec.op;
			req.wdata = rec.wdata;
			req.wmask = rec.mask;
			mem_req[rec.port] <= req;
			pending[rec.port] = 1'b1;
		end
		while (pending != '0) begin
			@(negedge clk);
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (pending[p] && mem_resp[p]) begin
					got[p] = mem_rdata[p];
					pending[p] = 1'b0;
				end
			end
			@(posedge clk);
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (!pending[p]) begin
					mem_req[p] <= '0;
				end
			end
		end
		for (int r = first; r <= last; r++) begin
			rec = recs[r];
			exp = ref_mem[rec.addr[15:1]];
			if (!rec.op) begin
				checks++;
				assert (got[rec.port] == exp) else begin
					$display("[FAIL] %0t port %0d read %h got %h expected %h", $time,
						rec.port, rec.addr, got[rec.port], exp);
					errors++;
				end
				if (rec.chk) begin
					checks++;
					assert (rec.exp_data == exp) else begin
						$display("[FAIL] %0t stim value %h for %h differs from reference %h",
							$time, rec.exp_data, rec.addr, exp);
						errors++;
					end
				end
			end else begin
				// byte enables merge into the reference word
				if (rec.mask[0]) begin
					ref_mem[rec.addr[15:1]][7:0] = rec.wdata[7:0];
				end
				if (rec.mask[1]) begin
					ref_mem[rec.addr[15:1]][15:8] = rec.wdata[15:8];
				end
			end
			if (first == last && rec.miss != 2'd3) begin
				checks++;
				assert ((pm_reads - rd0) == int'(rec.miss != 0)
					&& (pm_writes - wr0) == int'(rec.miss == 2)) else begin
					$display("[FAIL] %0t access %h made %0d reads %0d writes, miss type %0d",
						$time, rec.addr, pm_reads - rd0, pm_writes - wr0, rec.miss);
					errors++;
				end
				if (rec.miss != 0) begin
					checks++;
					assert (last_read_addr == {rec.addr[15:4], 4'h0}) else begin
						$display("[FAIL] %0t block read at %h for access %h", $time,
							last_read_addr, rec.addr);
						errors++;
					end
				end
			end
		end
	endtask

	initial begin
		int r;
		int last;
		int err0;
		int assert_fails;
		logic [31:0] v;
		rst_n = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			mem_req[p] = '0;
		end
		pmem_rdata_in = '0;
		pmem_resp_in = 1'b0;
		mem_busy = 1'b0;
		mem_wait = 0;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit = 0;
		pm_reads = 0;
		pm_writes = 0;
		lfsr = 32'hb304a7e4;
		for (int b = 0; b < 4096; b++) begin
			for (int w = 0; w < 4; w++) begin
				take_bits(32, v);
				pmem[b][w * 32 +: 32] = v;
			end
			for (int i = 0; i < 8; i++) begin
				ref_mem[b * 8 + i] = pmem[b][i * 16 +: 16];
			end
		end
		load_stim();
		limit = recs.size() * 40;
		repeat (4) begin
			@(negedge clk);
			checks++;
			assert (mem_resp == '0 && !pmem_out.read && !pmem_out.write) else begin
				$display("[FAIL] %0t outputs active during reset", $time);
				errors++;
			end
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		assert (mem_resp == '0 && !pmem_out.read && !pmem_out.write) else begin
			$display("[FAIL] %0t outputs active after reset", $time);
			errors++;
		end
		r = 0;
		for (int t = 0; t < test_names.size(); t++) begin
			err0 = errors;
			while (r < recs.size() && recs[r].test == 8'(t)) begin
				last = r;
				while (recs[last].par && last + 1 < recs.size()) begin
					last++;
				end
				run_batch(r, last);
				r = last + 1;
			end
			$display("test %0s: %0s", test_names[t], (errors == err0) ? "ok" : "FAILED");
		end
		assert_fails = lc3b_mem_inst.pmem_arbiter_inst.lc3b_mem_assert_inst.fail_count;
		if (assert_fails != 0) begin
			$display("arbiter assertions failed %0d times", assert_fails);
			errors += assert_fails;
		end
		$display("%0d tests, %0d checks, %0d errors", test_names.size(), checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule : lc3b_mem_tb

`default_nettype wire

//--- lc3b_mem.f
hw/lc3b_types.sv
hw/l1_cache.sv
hw/pmem_arbiter.sv
hw/lc3b_mem.sv
tests/lc3b_mem_assert.sv
tests/lc3b_mem_tb.sv

//--- Makefile
TOP = lc3b_mem_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f lc3b_mem.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@if ! grep -q "All tests passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- tests/lc3b_mem_stim.txt
# port op(0 read,1 write) addr wdata mask chk expect miss(0 hit,1 clean,2 dirty,3 any) par
# par 1 issues the line together with the next one
T reset
0 0 0040 0000 0 0 0000 1 0
T read_hit
0 0 0040 0000 0 0 0000 0 0
1 0 8000 0000 0 0 0000 1 0
1 0 8002 0000 0 0 0000 0 0
1 0 8000 0000 0 0 0000 0 0
T byte_mask
1 1 8004 1234 3 0 0000 0 0
1 0 8004 0000 0 1 1234 0 0
1 1 8004 abcd 1 0 0000 0 0
1 0 8004 0000 0 1 12cd 0 0
1 1 8004 5678 2 0 0000 0 0
1 0 8004 0000 0 1 56cd 0 0
T dirty_evict
1 0 8080 0000 0 0 0000 2 0
1 0 8004 0000 0 1 56cd 1 0
1 1 8090 0f0f 3 0 0000 1 0
1 0 8110 0000 0 0 0000 2 0
1 0 8090 0000 0 1 0f0f 1 0
T concurrent
0 0 0100 0000 0 0 0000 3 1
1 0 8200 0000 0 0 0000 3 0
0 0 0102 0000 0 0 0000 3 1
1 1 8204 beef 3 0 0000 3 0
1 0 8204 0000 0 1 beef 0 0
0 0 0102 0000 0 0 0000 0 0
0 0 0040 0000 0 0 0000 3 1
1 1 8206 0a0b 1 0 0000 3 0
1 0 8206 0000 0 0 0000 0 0
T same_index
0 0 0000 0000 0 0 0000 1 0
1 1 8300 c3c3 3 0 0000 2 0
0 0 0000 0000 0 0 0000 0 0
1 0 8300 0000 0 1 c3c3 0 0
0 0 0100 0000 0 0 0000 1 0
1 0 8000 0000 0 0 0000 2 0
1 0 8300 0000 0 1 c3c3 1 0
